// ==== beam_sum/beam_fifo.sv ====
// Register FIFO between beam summer and writer, first word falls through.
// The producer must not push when full, the consumer must not pop when empty.

`default_nettype none

module beam_fifo import sp_cfg_pkg::*; #(
	parameter int FIFO_DEPTH = FIFO_DEPTH_DEF		// entries, at least 2
) (
	input  logic		i_clk156m,		// system clock
	input  logic		i_rst_n,		// async reset, active low
	input  logic		i_push,			// write enable
	input  sp_word_t	i_push_data,	// write data
	input  logic		i_pop,			// read enable
	output sp_word_t	o_pop_data,		// head word
	output logic		o_full,			// no room
	output logic		o_empty			// no data
);

	localparam int AW = $clog2(FIFO_DEPTH);			// pointer width
	localparam int CW = $clog2(FIFO_DEPTH + 1);		// count width

	sp_word_t		r_mem [FIFO_DEPTH];		// storage
	logic [AW-1:0]	r_wr_ptr;				// next write slot
	logic [AW-1:0]	r_rd_ptr;				// head slot
	logic [CW-1:0]	r_count;				// words held

	function automatic logic [AW-1:0] f_next(input logic [AW-1:0] i_ptr);
		return (i_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : i_ptr + 1'b1;	// wrap for any depth
	endfunction

	assign o_pop_data = r_mem[r_rd_ptr];		// fall through
	assign o_full     = (r_count == CW'(FIFO_DEPTH));
	assign o_empty    = (r_count == '0);

	always_ff @(posedge i_clk156m) begin
		if (i_push) begin
			r_mem[r_wr_ptr] <= i_push_data;
		end
	end

	always_ff @(posedge i_clk156m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
		end else begin
			if (i_push) begin
				r_wr_ptr <= f_next(r_wr_ptr);
			end
			if (i_pop) begin
				r_rd_ptr <= f_next(r_rd_ptr);
			end
			case ({i_push, i_pop})
				2'b10:   r_count <= r_count + 1'b1;
				2'b01:   r_count <= r_count - 1'b1;
				default: r_count <= r_count;		// none or both
			endcase
		end
	end

	a_no_push_full: assert property (@(posedge i_clk156m) disable iff (!i_rst_n)
		o_full |-> !i_push);
	a_no_pop_empty: assert property (@(posedge i_clk156m) disable iff (!i_rst_n)
		o_empty |-> !i_pop);

endmodule

`default_nettype wire

// ==== beam_sum/beam_sum.sv ====
// Beam summer. Reads STAVE_NUM words per beam and adds them, wrapping at 32 bits.
// All reads of one beam finish before the next beam starts, so at most
// STAVE_NUM reads are outstanding. Read data must return in order.

`default_nettype none

module beam_sum import sp_cfg_pkg::*; import sp_ctrl_pkg::*; #(
	parameter logic [3:0]  CALC_NUM  = CALC_NUM_DEF,		// passes per frame
	parameter logic [9:0]  BEAM_NUM  = BEAM_NUM_DEF,		// beams per pass
	parameter logic [10:0] STAVE_NUM = STAVE_NUM_DEF		// staves per beam
) (
	input  logic		i_clk156m,			// system clock
	input  logic		i_rst_n,			// async reset, active low
	input  logic		i_calc_start,		// pass start pulse
	input  sp_word_t	i_iram_rd_data,		// read data
	input  logic		i_iram_rd_valid,	// read data valid
	input  logic		i_full,				// fifo full
	output sp_addr_t	o_iram_rd_addr,		// read address
	output logic		o_iram_rd_en,		// read enable
	output logic		o_push,				// fifo push
	output sp_word_t	o_push_data,		// beam sum
	output logic		o_pass_done			// last beam of pass pushed
);

	bsum_state_e	r_state;		// summer state
	logic [3:0]		r_pass_cnt;		// pass within frame
	logic [9:0]		r_beam_cnt;		// beam within pass
	logic [10:0]	r_iss_cnt;		// reads issued for this beam
	logic [10:0]	r_rcv_cnt;		// reads returned for this beam
	sp_word_t		r_acc;			// running beam sum
	logic			w_last_beam;	// final beam of the pass

	// (pass * BEAM_NUM + beam) * STAVE_NUM + stave
	assign o_iram_rd_addr = (sp_addr_t'(r_pass_cnt) * sp_addr_t'(BEAM_NUM)
						  + sp_addr_t'(r_beam_cnt)) * sp_addr_t'(STAVE_NUM)
						  + sp_addr_t'(r_iss_cnt);
	assign o_iram_rd_en   = (r_state == BS_READ) && (r_iss_cnt != STAVE_NUM);
	assign o_push         = (r_state == BS_PUSH) && !i_full;	// hold sum while full
	assign o_push_data    = r_acc;
	assign w_last_beam    = (r_beam_cnt == BEAM_NUM - 10'd1);

	// accumulator, restarts at each beam
	always_ff @(posedge i_clk156m) begin
		if (i_calc_start || o_push) begin
			r_acc <= '0;
		end else if (i_iram_rd_valid) begin
			r_acc <= r_acc + i_iram_rd_data;		// integer add, wraps
		end
	end

	always_ff @(posedge i_clk156m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state     <= BS_IDLE;
			r_pass_cnt  <= 4'd0;
			r_beam_cnt  <= 10'd0;
			r_iss_cnt   <= 11'd0;
			r_rcv_cnt   <= 11'd0;
			o_pass_done <= 1'b0;
		end else begin
			o_pass_done <= 1'b0;
			case (r_state)
				BS_IDLE: begin
					if (i_calc_start) begin
						r_state    <= BS_READ;		// first read next cycle
						r_beam_cnt <= 10'd0;
						r_iss_cnt  <= 11'd0;
						r_rcv_cnt  <= 11'd0;
					end
				end
				BS_READ: begin
					if (o_iram_rd_en) begin
						r_iss_cnt <= r_iss_cnt + 11'd1;
					end
					if (i_iram_rd_valid) begin
						r_rcv_cnt <= r_rcv_cnt + 11'd1;
						if (r_rcv_cnt == STAVE_NUM - 11'd1) begin
							r_state <= BS_PUSH;		// beam complete
						end
					end
				end
				BS_PUSH: begin
					if (!i_full) begin
						r_iss_cnt <= 11'd0;
						r_rcv_cnt <= 11'd0;
						if (w_last_beam) begin
							r_state     <= BS_IDLE;
							o_pass_done <= 1'b1;
							// wraps to 0, so the next frame starts at pass 0
							r_pass_cnt  <= (r_pass_cnt == CALC_NUM - 4'd1) ? 4'd0
										 : r_pass_cnt + 4'd1;
						end else begin
							r_state    <= BS_READ;
							r_beam_cnt <= r_beam_cnt + 10'd1;
						end
					end
				end
				default: r_state <= BS_IDLE;
			endcase
		end
	end

	// ram only returns data for reads that were issued
	a_no_stray_valid: assert property (@(posedge i_clk156m) disable iff (!i_rst_n)
		i_iram_rd_valid |-> (r_state == BS_READ) && (r_iss_cnt != r_rcv_cnt));

endmodule

`default_nettype wire

// ==== bench/sp_patterns.hex ====
// lines 1-6: input RAM, addresses 0..23, one beam per line (staves 0..3)
// lines 7-9: expected output writes in order (beam sums, pad words, end code)
00000001 00000002 00000003 00000004
10000000 20000000 30000000 40000000
8ffffff0 70000020 00000005 00000006
7fc00001 00400000 00000010 00000020
12345678 11111111 01010101 00000000
deadbeef 21524111 00000000 00000001
0000000a a0000000 0000001b 00000000 00000000
80000031 2446688a 00000001 00000000 00000000
ffffffff

// ==== bench/tb_sp_main.sv ====
// Testbench for the beam processing top with default sizes (2 passes, 3 beams, 4 staves).
// RAM image and expected writes come from bench/sp_patterns.hex, run from the project root.
// Input RAM model answers in order with a random latency of 1 to 3 cycles.

`default_nettype none

module tb_sp_main import sp_cfg_pkg::*; ();

	localparam int N_RAM = int'(CALC_NUM_DEF) * int'(BEAM_NUM_DEF) * int'(STAVE_NUM_DEF);
	localparam int N_EXP = int'(CALC_NUM_DEF) * (int'(BEAM_NUM_DEF) + int'(PAD_SIZE_DEF)) + 1;
	localparam int N_PAT = N_RAM + N_EXP;		// ram words, then expected writes
	localparam int FRAME_TIMEOUT = 500;			// cycles from start to o_sp_end

	logic		i_clk156m;
	logic		i_rst_n;
	logic		i_sp_start;
	sp_word_t	i_iram_rd_data;
	logic		i_iram_rd_valid;
	sp_addr_t	o_iram_rd_addr;
	logic		o_iram_rd_en;
	sp_word_t	o_oram_wr_data;
	logic		o_oram_wr_valid;
	logic		o_sp_end;
	logic [1:0]	o_nan_err;

	sp_word_t		pat_mem [N_PAT];		// file contents
	sp_addr_t		rd_addr_q [$];			// reads in flight
	int				rd_due_q [$];			// cycle each read answers
	logic [31:0]	lfsr = 32'hc37e_f28d;
	int				cyc = 0;				// cycle count, nba updated
	int				last_due = -1;			// keeps answers in order
	int				out_idx = 0;			// writes seen this frame
	int				last_wr_cyc = 0;		// cycle of final frame word
	int				sp_end_cnt = 0;			// end pulses this frame
	logic			frame_on = 1'b0;		// monitor enable
	int				err_cnt = 0;			// value mismatches
	int				misc_cnt = 0;			// protocol errors
	int				timeout_cnt = 0;

	sp_main_top DUT (.*);

	initial begin
		i_clk156m = 1'b0;
		forever #20 i_clk156m = ~i_clk156m;
	end

	always @(posedge i_clk156m) cyc <= cyc + 1;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	task automatic check_word(input string name, input sp_word_t got, input sp_word_t exp);
		if (got !== exp) begin
			$display("FAIL %s: got %h, expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_flags(input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			$display("FAIL o_nan_err: got %h, expected %h", got, exp);
			err_cnt++;
		end
	endtask

	// ------------------------------------------------------------
	// input ram model
	// ------------------------------------------------------------
	always @(posedge i_clk156m) begin : ram_model
		logic [1:0]	pick;
		int			due;
		sp_addr_t	addr;
		if (!i_rst_n) begin
			i_iram_rd_valid <= 1'b0;
		end else begin
			if (o_iram_rd_en) begin
				lfsr = lfsr_next(lfsr);
				pick[1] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				pick[0] = lfsr[0];
				due = cyc + int'(pick % 2'd3);		// latency 1..3
				if (due <= last_due) due = last_due + 1;
				last_due = due;
				rd_addr_q.push_back(o_iram_rd_addr);
				rd_due_q.push_back(due);
			end
			if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
				addr = rd_addr_q.pop_front();
				void'(rd_due_q.pop_front());
				if (addr >= sp_addr_t'(N_RAM)) begin
					$display("ERROR: read address %h is outside the input RAM", addr);
					misc_cnt++;
					i_iram_rd_data <= '0;
				end else begin
					i_iram_rd_data <= pat_mem[addr];
				end
				i_iram_rd_valid <= 1'b1;
			end else begin
				i_iram_rd_valid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// output monitor
	// ------------------------------------------------------------
	always @(posedge i_clk156m) begin
		if (i_rst_n && frame_on) begin
			if (o_oram_wr_valid) begin
				if (out_idx < N_EXP) begin
					check_word("o_oram_wr_data", o_oram_wr_data, pat_mem[N_RAM + out_idx]);
				end else begin
					$display("ERROR: output word %0d is beyond the end of the frame", out_idx);
					misc_cnt++;
				end
				out_idx++;
				last_wr_cyc = cyc;
			end
			if (o_sp_end) begin
				sp_end_cnt++;
				if (out_idx != N_EXP || last_wr_cyc != cyc - 1) begin
					$display("ERROR: o_sp_end did not come one cycle after the end code");
					misc_cnt++;
				end
			end
		end
	end

	task automatic run_frame(inout int ok);
		int wait_cnt;
		out_idx = 0;
		sp_end_cnt = 0;
		frame_on = 1'b1;
		@(posedge i_clk156m);
		i_sp_start <= 1'b1;
		@(posedge i_clk156m);
		i_sp_start <= 1'b0;
		@(posedge i_clk156m);
		check_flags(o_nan_err, 2'b00);			// cleared by start
		wait_cnt = 0;
		while (sp_end_cnt == 0 && wait_cnt < FRAME_TIMEOUT) begin
			@(posedge i_clk156m);
			wait_cnt++;
		end
		if (sp_end_cnt == 0) begin
			$display("TIMEOUT: no o_sp_end within %0d cycles of the start", FRAME_TIMEOUT);
			timeout_cnt++;
			ok = 0;
		end else begin
			check_flags(o_nan_err, 2'b01);		// nan word read, sums clean
			repeat (8) @(posedge i_clk156m);	// catch stray words or pulses
			if (out_idx != N_EXP) begin
				$display("ERROR: frame wrote %0d words instead of %0d", out_idx, N_EXP);
				misc_cnt++;
			end
			if (sp_end_cnt != 1) begin
				$display("ERROR: o_sp_end pulsed %0d times in one frame", sp_end_cnt);
				misc_cnt++;
			end
		end
	endtask

	initial begin : main
		int ok;
		i_rst_n = 1'b0;
		i_sp_start = 1'b0;
		i_iram_rd_data = '0;
		i_iram_rd_valid = 1'b0;
		ok = 1;
		$readmemh("bench/sp_patterns.hex", pat_mem);
		if ($isunknown(pat_mem[N_PAT-1])) begin
			$display("ERROR: bench/sp_patterns.hex could not be read completely");
			misc_cnt++;
			ok = 0;
		end
		repeat (8) @(posedge i_clk156m);
		i_rst_n <= 1'b1;
		repeat (12) begin								// quiet after reset
			@(posedge i_clk156m);
			if (o_oram_wr_valid || o_sp_end) begin
				$display("ERROR: output activity before any start");
				misc_cnt++;
			end
		end
		check_flags(o_nan_err, 2'b00);
		if (ok) run_frame(ok);
		if (ok) begin
			repeat (6) @(posedge i_clk156m);
			check_flags(o_nan_err, 2'b01);			// sticky while idle
			run_frame(ok);							// pass count restarts
		end
		$display("errors: %0d value, %0d other, %0d timeout", err_cnt, misc_cnt, timeout_cnt);
		if (err_cnt + misc_cnt + timeout_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/sp_cfg_pkg.sv ====
// Data widths, word types and default sizes for the beam path.
// Data words are treated as 32-bit integers for the beam sum and wrap on overflow.
// The exponent and mantissa widths describe IEEE single precision and are used for the NaN check.

`default_nettype none

package sp_cfg_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int SP_DATA_W = 32;		// ram data word
	localparam int SP_ADDR_W = 32;		// input ram read address
	localparam int SP_EXP_W  = 8;		// float exponent field
	localparam int SP_MAN_W  = 23;		// float mantissa field

	typedef logic [SP_DATA_W-1:0] sp_word_t;	// one ram word
	typedef logic [SP_ADDR_W-1:0] sp_addr_t;	// one read address

	// ------------------------------------------------------------
	// default sizes, overridden from the top level
	// ------------------------------------------------------------
	localparam logic [3:0]  CALC_NUM_DEF   = 4'd2;		// passes per frame
	localparam logic [9:0]  BEAM_NUM_DEF   = 10'd3;		// beams per pass
	localparam logic [10:0] STAVE_NUM_DEF  = 11'd4;		// staves summed per beam
	localparam logic [7:0]  PAD_SIZE_DEF   = 8'd2;		// pad words after a pass
	localparam int          FIFO_DEPTH_DEF = 4;			// beam fifo entries

endpackage

`default_nettype wire

// ==== common/sp_ctrl_pkg.sv ====
// FSM states and fixed output words of the frame control.
// The end code is all ones, so it looks like a NaN and is skipped by the output NaN check.

`default_nettype none

package sp_ctrl_pkg;

	// frame sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,		// waiting for start
		SEQ_CALC,		// pass start cycle
		SEQ_JOIN		// pass running, wait for writer
	} seq_state_e;

	// beam summer
	typedef enum logic [1:0] {
		BS_IDLE,		// no pass
		BS_READ,		// issuing reads, accumulating
		BS_PUSH			// sum ready, wait for fifo room
	} bsum_state_e;

	// output word kind of the writer
	typedef enum logic [1:0] {
		JN_DATA,		// beam words from fifo
		JN_PAD,			// padding words
		JN_END			// end code word
	} join_state_e;

	localparam logic [31:0] SP_END_CODE = 32'hffff_ffff;	// frame end marker
	localparam logic [31:0] SP_PAD_WORD = 32'h0000_0000;	// padding word

endpackage

`default_nettype wire

// ==== compile.f ====
common/sp_cfg_pkg.sv
common/sp_ctrl_pkg.sv
verilog/sp_seq_ctrl.sv
beam_sum/beam_sum.sv
beam_sum/beam_fifo.sv
pad_join/pad_join.sv
verilog/nan_check.sv
verilog/sp_main_top.sv
bench/tb_sp_main.sv

// ==== pad_join/pad_join.sv ====
// Output writer. Writes the beam words of a pass, then PAD_SIZE pad words,
// then the end code on the last pass. o_join_end comes with the final write.
// With PAD_SIZE of 0 on a middle pass, o_join_end pulses without a write.

`default_nettype none

module pad_join import sp_cfg_pkg::*; import sp_ctrl_pkg::*; #(
	parameter logic [9:0] BEAM_NUM = BEAM_NUM_DEF,		// beams per pass
	parameter logic [7:0] PAD_SIZE = PAD_SIZE_DEF		// pad words per pass
) (
	input  logic		i_clk156m,			// system clock
	input  logic		i_rst_n,			// async reset, active low
	input  logic		i_pass_done,		// summer pushed last beam
	input  logic		i_last_pass,		// final pass of frame
	input  logic		i_empty,			// fifo empty
	input  sp_word_t	i_pop_data,			// fifo head word
	output logic		o_pop,				// fifo pop
	output sp_word_t	o_oram_wr_data,		// output ram data
	output logic		o_oram_wr_valid,	// output ram write
	output logic		o_join_end			// pass written
);

	join_state_e	r_state;		// current word kind
	logic [9:0]		r_beam_cnt;		// beam words written this pass
	logic [7:0]		r_pad_cnt;		// pad words written
	logic			r_done;			// pass done seen
	logic			w_pass_ready;	// all beams out, start tail

	assign o_pop        = (r_state == JN_DATA) && !i_empty;		// pop whenever data
	assign w_pass_ready = (r_state == JN_DATA) && r_done && i_empty
						&& (r_beam_cnt == BEAM_NUM);

	// write data, qualified by o_oram_wr_valid
	always_ff @(posedge i_clk156m) begin
		if (o_pop) begin
			o_oram_wr_data <= i_pop_data;
		end else if (r_state == JN_END) begin
			o_oram_wr_data <= SP_END_CODE;
		end else begin
			o_oram_wr_data <= SP_PAD_WORD;
		end
	end

	always_ff @(posedge i_clk156m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state         <= JN_DATA;
			r_beam_cnt      <= 10'd0;
			r_pad_cnt       <= 8'd0;
			r_done          <= 1'b0;
			o_oram_wr_valid <= 1'b0;
			o_join_end      <= 1'b0;
		end else begin
			o_oram_wr_valid <= o_pop || (r_state != JN_DATA);	// pad and end always write
			o_join_end      <= 1'b0;
			case (r_state)
				JN_DATA: begin
					if (i_pass_done) begin
						r_done <= 1'b1;
					end
					if (o_pop) begin
						r_beam_cnt <= r_beam_cnt + 10'd1;
					end
					if (w_pass_ready) begin
						r_done     <= 1'b0;
						r_beam_cnt <= 10'd0;
						r_pad_cnt  <= 8'd0;
						if (PAD_SIZE != 8'd0) begin
							r_state <= JN_PAD;
						end else if (i_last_pass) begin
							r_state <= JN_END;
						end else begin
							o_join_end <= 1'b1;		// nothing to append
						end
					end
				end
				JN_PAD: begin
					r_pad_cnt <= r_pad_cnt + 8'd1;
					if (r_pad_cnt == PAD_SIZE - 8'd1) begin
						if (i_last_pass) begin
							r_state <= JN_END;
						end else begin
							r_state    <= JN_DATA;
							o_join_end <= 1'b1;	// with last pad word
						end
					end
				end
				JN_END: begin
					r_state    <= JN_DATA;
					o_join_end <= 1'b1;			// with end code
				end
				default: r_state <= JN_DATA;
			endcase
		end
	end

	// summer finishes a pass only while the writer is still taking beam words
	a_pass_done_in_data: assert property (@(posedge i_clk156m) disable iff (!i_rst_n)
		i_pass_done |-> (r_state == JN_DATA) && !r_done);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, the verdict comes from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_sp_main -f compile.f \
	&& ./obj_dir/Vtb_sp_main | tee /dev/stderr | grep -qx "Test passed" \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// ==== verilog/nan_check.sv ====
// Sticky NaN flags on input read data and output write data.
// The end code on the output is a frame marker and is not checked.

`default_nettype none

module nan_check import sp_cfg_pkg::*; import sp_ctrl_pkg::*; (
	input  logic		i_clk156m,		// system clock
	input  logic		i_rst_n,		// async reset, active low
	input  logic		i_clr,			// clear both flags
	input  sp_word_t	i_in_data,		// input ram read data
	input  logic		i_in_valid,		// input data valid
	input  sp_word_t	i_out_data,		// output ram write data
	input  logic		i_out_valid,	// output data valid
	output logic [1:0]	o_nan_err		// [0] input nan, [1] output nan
);

	logic	w_in_nan;		// nan on input this cycle
	logic	w_out_nan;		// nan on output this cycle

	// exponent all ones, mantissa nonzero
	function automatic logic f_is_nan(input sp_word_t i_word);
		return (&i_word[SP_DATA_W-2 -: SP_EXP_W]) && (|i_word[SP_MAN_W-1:0]);
	endfunction

	assign w_in_nan  = i_in_valid && f_is_nan(i_in_data);
	assign w_out_nan = i_out_valid && f_is_nan(i_out_data) && (i_out_data != SP_END_CODE);

	always_ff @(posedge i_clk156m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_nan_err <= 2'b00;
		end else if (i_clr) begin
			o_nan_err <= 2'b00;							// new frame
		end else begin
			o_nan_err <= o_nan_err | {w_out_nan, w_in_nan};	// sticky
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sp_main_top.sv ====
// Sonar beam processing top. One start pulse runs CALC_NUM passes of one frame.
// Input RAM reads may have any latency but must return in order.
// The output RAM is assumed never to stall.

`default_nettype none

module sp_main_top import sp_cfg_pkg::*; #(
	parameter logic [3:0]  CALC_NUM   = CALC_NUM_DEF,		// passes per frame
	parameter logic [9:0]  BEAM_NUM   = BEAM_NUM_DEF,		// beams per pass
	parameter logic [10:0] STAVE_NUM  = STAVE_NUM_DEF,		// staves per beam
	parameter logic [7:0]  PAD_SIZE   = PAD_SIZE_DEF,		// pad words per pass
	parameter int          FIFO_DEPTH = FIFO_DEPTH_DEF		// beam fifo depth
) (
	input  logic		i_clk156m,			// system clock
	input  logic		i_rst_n,			// async reset, active low
	input  logic		i_sp_start,			// frame start pulse
	input  sp_word_t	i_iram_rd_data,		// input ram read data
	input  logic		i_iram_rd_valid,	// input ram read data valid
	output sp_addr_t	o_iram_rd_addr,		// input ram read address
	output logic		o_iram_rd_en,		// input ram read enable
	output sp_word_t	o_oram_wr_data,		// output ram write data
	output logic		o_oram_wr_valid,	// output ram write valid
	output logic		o_sp_end,			// frame end pulse
	output logic [1:0]	o_nan_err			// sticky nan flags, [0] in, [1] out
);

	logic		w_calc_start;	// seq => beam_sum
	logic		w_last_pass;	// seq => pad_join
	logic		w_join_end;		// pad_join => seq
	logic		w_push;			// beam_sum => fifo
	sp_word_t	w_push_data;	// beam_sum => fifo
	logic		w_full;			// fifo => beam_sum
	logic		w_empty;		// fifo => pad_join
	logic		w_pop;			// pad_join => fifo
	sp_word_t	w_pop_data;		// fifo => pad_join
	logic		w_pass_done;	// beam_sum => pad_join

	// ------------------------------------------------------------
	// frame control
	// ------------------------------------------------------------
	sp_seq_ctrl #(
		.CALC_NUM		(CALC_NUM)
	) u_seq_ctrl (
		.i_clk156m		(i_clk156m),
		.i_rst_n		(i_rst_n),
		.i_sp_start		(i_sp_start),
		.i_join_end		(w_join_end),
		.o_calc_start	(w_calc_start),
		.o_last_pass	(w_last_pass),
		.o_sp_end		(o_sp_end)
	);

	// ------------------------------------------------------------
	// beam path: summer -> fifo -> writer
	// ------------------------------------------------------------
	beam_sum #(
		.CALC_NUM		(CALC_NUM),
		.BEAM_NUM		(BEAM_NUM),
		.STAVE_NUM		(STAVE_NUM)
	) u_beam_sum (
		.i_clk156m			(i_clk156m),
		.i_rst_n			(i_rst_n),
		.i_calc_start		(w_calc_start),
		.i_iram_rd_data		(i_iram_rd_data),
		.i_iram_rd_valid	(i_iram_rd_valid),
		.i_full				(w_full),
		.o_iram_rd_addr		(o_iram_rd_addr),
		.o_iram_rd_en		(o_iram_rd_en),
		.o_push				(w_push),
		.o_push_data		(w_push_data),
		.o_pass_done		(w_pass_done)
	);

	beam_fifo #(
		.FIFO_DEPTH		(FIFO_DEPTH)
	) u_beam_fifo (
		.i_clk156m		(i_clk156m),
		.i_rst_n		(i_rst_n),
		.i_push			(w_push),
		.i_push_data	(w_push_data),
		.i_pop			(w_pop),
		.o_pop_data		(w_pop_data),
		.o_full			(w_full),
		.o_empty		(w_empty)
	);

	pad_join #(
		.BEAM_NUM		(BEAM_NUM),
		.PAD_SIZE		(PAD_SIZE)
	) u_pad_join (
		.i_clk156m			(i_clk156m),
		.i_rst_n			(i_rst_n),
		.i_pass_done		(w_pass_done),
		.i_last_pass		(w_last_pass),
		.i_empty			(w_empty),
		.i_pop_data			(w_pop_data),
		.o_pop				(w_pop),
		.o_oram_wr_data		(o_oram_wr_data),
		.o_oram_wr_valid	(o_oram_wr_valid),
		.o_join_end			(w_join_end)
	);

	// nan flags, cleared at each frame start
	nan_check u_nan_check (
		.i_clk156m		(i_clk156m),
		.i_rst_n		(i_rst_n),
		.i_clr			(i_sp_start),
		.i_in_data		(i_iram_rd_data),
		.i_in_valid		(i_iram_rd_valid),
		.i_out_data		(o_oram_wr_data),
		.i_out_valid	(o_oram_wr_valid),
		.o_nan_err		(o_nan_err)
	);

endmodule

`default_nettype wire

// ==== verilog/sp_seq_ctrl.sv ====
// Frame sequencer. Runs CALC_NUM passes per start pulse, start is ignored while busy.
// Each pass begins one cycle after the writer's join end pulse.

`default_nettype none

module sp_seq_ctrl import sp_cfg_pkg::*; import sp_ctrl_pkg::*; #(
	parameter logic [3:0] CALC_NUM = CALC_NUM_DEF		// passes per frame
) (
	input  logic	i_clk156m,		// system clock
	input  logic	i_rst_n,		// async reset, active low
	input  logic	i_sp_start,		// frame start pulse
	input  logic	i_join_end,		// writer finished a pass
	output logic	o_calc_start,	// pass start pulse
	output logic	o_last_pass,	// high during final pass
	output logic	o_sp_end		// frame end pulse
);

	seq_state_e	r_state;		// sequencer state
	logic [3:0]	r_pass_cnt;		// current pass, 0 based
	logic		w_final;		// current pass is the last one

	assign w_final      = (r_pass_cnt == CALC_NUM - 4'd1);
	assign o_calc_start = (r_state == SEQ_CALC);			// one cycle per pass
	assign o_last_pass  = (r_state != SEQ_IDLE) && w_final;

	always_ff @(posedge i_clk156m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state    <= SEQ_IDLE;
			r_pass_cnt <= 4'd0;
			o_sp_end   <= 1'b0;
		end else begin
			o_sp_end <= 1'b0;							// pulse default
			case (r_state)
				SEQ_IDLE: begin
					if (i_sp_start) begin
						r_state    <= SEQ_CALC;
						r_pass_cnt <= 4'd0;				// new frame
					end
				end
				SEQ_CALC: r_state <= SEQ_JOIN;			// start issued, pass runs
				SEQ_JOIN: begin
					if (i_join_end) begin
						if (w_final) begin
							r_state  <= SEQ_IDLE;
							o_sp_end <= 1'b1;			// one cycle after end code
						end else begin
							r_state    <= SEQ_CALC;
							r_pass_cnt <= r_pass_cnt + 4'd1;
						end
					end
				end
				default: r_state <= SEQ_IDLE;
			endcase
		end
	end

	// the writer only ends a pass while the sequencer waits for it
	a_join_end_in_join: assert property (@(posedge i_clk156m) disable iff (!i_rst_n)
		i_join_end |-> (r_state == SEQ_JOIN));

endmodule

`default_nettype wire
